// File: logic/reflex_params.svh
`default_nettype none

`ifndef REFLEX_PARAMS_SVH
`define REFLEX_PARAMS_SVH

////////////////////
// word widths
////////////////////

// data word, two endpoint halves
`define REFLEX_WORD_W 32
// host trigger strobe vector
`define REFLEX_TRIG_W 16

////////////////////
// scaled constants
////////////////////

// epsc for one spike, x1024 scaling
`define REFLEX_EPSC_UNIT 1024
// 30 mV threshold, same x1024 scaling
`define REFLEX_TH_SCALED 30720
// neuron ticks per population window
`define REFLEX_WINDOW_TICKS 128

// reset values of the parameter bank
`define REFLEX_DELAY_RST 9
`define REFLEX_GAIN_RST 1

`endif

`default_nettype wire

// File: logic/host_pkg.sv
`default_nettype none

package host_pkg;

    ////////////////////
    // host side words
    ////////////////////

    // one endpoint wire, half a data word
    typedef logic [15:0] ep_half_t;

    // bit positions in the trigger strobe vector
    // gaps are triggers of dropped parameters
    typedef enum logic [3:0] {
        TRIG_DELAY       = 4'd0,
        TRIG_GAIN_CN_MN  = 4'd3,
        TRIG_GAIN_SN_MN  = 4'd6,
        TRIG_GAIN_CN2_MN = 4'd9,
        TRIG_M1_DRIVE    = 4'd10,
        TRIG_GAIN_SN_CN  = 4'd12
    } trig_idx_e;

endpackage

`default_nettype wire

// File: logic/neuro_pkg.sv
`default_nettype none

package neuro_pkg;

    ////////////////////
    // neural data words
    ////////////////////

    // synaptic current or summed drive, x1024 scaled
    typedef logic signed [31:0] current_t;

    // membrane state, same scaling as current
    typedef logic signed [31:0] membrane_t;

    // spikes seen in one population window
    typedef logic [31:0] spkcnt_t;

endpackage

`default_nettype wire

// File: logic/param_bank.sv
`timescale 1ns/100ps
`include "reflex_params.svh"
`default_nettype none

module param_bank
(
    input  wire logic                          ep50trig,
    input  wire logic                          reset_sim,
    input  wire logic [`REFLEX_TRIG_W-1:0]     i_trig,
    input  wire host_pkg::ep_half_t            i_ep01,
    input  wire host_pkg::ep_half_t            i_ep02,
    input  wire host_pkg::ep_half_t            i_ep05,
    input  wire host_pkg::ep_half_t            i_ep06,
    input  wire host_pkg::ep_half_t            i_ep07,
    input  wire host_pkg::ep_half_t            i_ep08,
    output logic [`REFLEX_WORD_W-1:0]          o_delay_max,
    output logic [`REFLEX_WORD_W-1:0]          o_gain_sn_mn,
    output logic [`REFLEX_WORD_W-1:0]          o_gain_sn_cn,
    output logic [`REFLEX_WORD_W-1:0]          o_gain_cn_mn,
    output logic [`REFLEX_WORD_W-1:0]          o_gain_cn2_mn,
    output neuro_pkg::current_t                o_m1_cn_drive,
    output neuro_pkg::current_t                o_m1_cn2_drive
);

    import host_pkg::*;

    // common word for single-register triggers
    // ep02 high half, ep01 low half
    logic [`REFLEX_WORD_W-1:0] ep_word;

    assign ep_word = {i_ep02, i_ep01};

    ////////////////////
    // trigger loads
    ////////////////////

    // each bit loads independently, several may hit at once
    // unnamed bits fall through untouched
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_delay_max    <= `REFLEX_WORD_W'(`REFLEX_DELAY_RST);
            o_gain_sn_mn   <= `REFLEX_WORD_W'(`REFLEX_GAIN_RST);
            o_gain_sn_cn   <= `REFLEX_WORD_W'(`REFLEX_GAIN_RST);
            o_gain_cn_mn   <= `REFLEX_WORD_W'(`REFLEX_GAIN_RST);
            o_gain_cn2_mn  <= `REFLEX_WORD_W'(`REFLEX_GAIN_RST);
            // voluntary drive off
            o_m1_cn_drive  <= '0;
            o_m1_cn2_drive <= '0;
        end
        else
        begin
            // divider period of the neuron tick
            if (i_trig[TRIG_DELAY])
                o_delay_max <= ep_word;
            if (i_trig[TRIG_GAIN_CN_MN])
                o_gain_cn_mn <= ep_word;
            // shared by the Ia and II paths
            if (i_trig[TRIG_GAIN_SN_MN])
                o_gain_sn_mn <= ep_word;
            if (i_trig[TRIG_GAIN_CN2_MN])
                o_gain_cn2_mn <= ep_word;
            // both m1 drives on one strobe, own endpoint pairs
            if (i_trig[TRIG_M1_DRIVE])
            begin
                o_m1_cn_drive  <= {i_ep06, i_ep05};
                o_m1_cn2_drive <= {i_ep08, i_ep07};
            end
            if (i_trig[TRIG_GAIN_SN_CN])
                o_gain_sn_cn <= ep_word;
        end
    end

endmodule

`default_nettype wire

// File: logic/tick_timer.sv
`timescale 1ns/100ps
`include "reflex_params.svh"
`default_nettype none

module tick_timer
(
    input  wire logic                      ep50trig,
    input  wire logic                      reset_sim,
    input  wire logic [`REFLEX_WORD_W-1:0] i_delay_max,
    output logic                           o_tick,
    output logic                           o_window_end
);

    localparam int WIN_W = $clog2(`REFLEX_WINDOW_TICKS);

    // cycles since last tick
    logic [`REFLEX_WORD_W-1:0] period_cnt;
    // ticks since window start
    logic [WIN_W-1:0]          tick_cnt;

    // ">=" so a shrunk delay ends the period at once
    assign o_tick = (period_cnt >= i_delay_max);

    // last tick of the window
    assign o_window_end = o_tick && (tick_cnt == WIN_W'(`REFLEX_WINDOW_TICKS - 1));

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            period_cnt <= '0;
            tick_cnt   <= '0;
        end
        else if (o_tick)
        begin
            // restart period, window wraps by itself
            period_cnt <= '0;
            tick_cnt   <= tick_cnt + 1'b1;
        end
        else
        begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/synapse_epsc.sv
`timescale 1ns/100ps
`include "reflex_params.svh"
`default_nettype none

module synapse_epsc
(
    input  wire logic                      ep50trig,
    input  wire logic                      reset_sim,
    input  wire logic                      i_tick,
    input  wire logic                      i_spk,
    input  wire logic [`REFLEX_WORD_W-1:0] i_gain,
    output neuro_pkg::current_t            o_epsc
);

    import neuro_pkg::*;

    // unit epsc times gain, low word only
    logic [`REFLEX_WORD_W-1:0] scaled;

    assign scaled = i_gain * `REFLEX_WORD_W'(`REFLEX_EPSC_UNIT);

    // sampled once per tick, held in between
    // doubles as the drive latch of the neuron stage
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_epsc <= '0;
        else if (i_tick)
        begin
            if (i_spk)
                o_epsc <= current_t'(scaled);
            else
                o_epsc <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/if_neuron.sv
`timescale 1ns/100ps
`include "reflex_params.svh"
`default_nettype none

module if_neuron
(
    input  wire logic                ep50trig,
    input  wire logic                reset_sim,
    input  wire logic                i_tick,
    input  wire neuro_pkg::current_t i_drive,
    output logic                     o_spk
);

    import neuro_pkg::*;

    localparam int SUM_W = `REFLEX_WORD_W + 1;

    membrane_t              membrane;
    // one guard bit, large drives must not wrap
    logic signed [SUM_W-1:0] v_next;

    assign v_next = SUM_W'(membrane) + SUM_W'(i_drive);

    ////////////////////
    // integrate and fire
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            membrane <= '0;
            o_spk    <= 1'b0;
        end
        else if (i_tick)
        begin
            if (v_next >= SUM_W'(`REFLEX_TH_SCALED))
            begin
                // fire, membrane back to rest
                o_spk    <= 1'b1;
                membrane <= '0;
            end
            else
            begin
                o_spk    <= 1'b0;
                // no leak, floor at zero
                membrane <= (v_next < 0) ? membrane_t'(0) : membrane_t'(v_next);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/spike_window_counter.sv
`timescale 1ns/100ps
`default_nettype none

module spike_window_counter
(
    input  wire logic           ep50trig,
    input  wire logic           reset_sim,
    input  wire logic           i_tick,
    input  wire logic           i_window_end,
    input  wire logic           i_spk,
    output neuro_pkg::spkcnt_t  o_count
);

    import neuro_pkg::*;

    // running count of the open window
    spkcnt_t acc;
    // count with this tick included
    spkcnt_t acc_next;

    assign acc_next = acc + spkcnt_t'(i_spk);

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            acc     <= '0;
            o_count <= '0;
        end
        else if (i_tick)
        begin
            if (i_window_end)
            begin
                // publish total, start the next window empty
                o_count <= acc_next;
                acc     <= '0;
            end
            else
                acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/reflex_loop_top.sv
`timescale 1ns/100ps
`include "reflex_params.svh"
`default_nettype none

module reflex_loop_top
(
    input  wire logic                      ep50trig,
    input  wire logic                      reset_sim,
    input  wire logic [`REFLEX_TRIG_W-1:0] i_trig,
    input  wire host_pkg::ep_half_t        i_ep01,
    input  wire host_pkg::ep_half_t        i_ep02,
    input  wire host_pkg::ep_half_t        i_ep05,
    input  wire host_pkg::ep_half_t        i_ep06,
    input  wire host_pkg::ep_half_t        i_ep07,
    input  wire host_pkg::ep_half_t        i_ep08,
    input  wire logic                      i_sn_ia_spk,
    input  wire logic                      i_sn_ii_spk,
    output logic                           o_tick,
    output logic                           o_cn_spk,
    output logic                           o_cn2_spk,
    output logic                           o_mn_spk,
    output neuro_pkg::current_t            o_epsc_cn_to_mn,
    output neuro_pkg::spkcnt_t             o_mn_spkcnt
);

    import neuro_pkg::*;

    logic [`REFLEX_WORD_W-1:0] delay_max;
    logic [`REFLEX_WORD_W-1:0] gain_sn_mn, gain_sn_cn, gain_cn_mn, gain_cn2_mn;
    current_t                  m1_cn_drive, m1_cn2_drive;
    logic                      window_end;

    // epsc registers
    current_t epsc_ia_mn, epsc_ii_mn, epsc_sn_cn, epsc_cn2_mn;
    // neuron drives
    current_t cn_drive, cn2_drive, mn_drive;

    ////////////////////
    // host parameters and tick
    ////////////////////

    param_bank u_bank (
        .ep50trig       (ep50trig),
        .reset_sim      (reset_sim),
        .i_trig         (i_trig),
        .i_ep01         (i_ep01),
        .i_ep02         (i_ep02),
        .i_ep05         (i_ep05),
        .i_ep06         (i_ep06),
        .i_ep07         (i_ep07),
        .i_ep08         (i_ep08),
        .o_delay_max    (delay_max),
        .o_gain_sn_mn   (gain_sn_mn),
        .o_gain_sn_cn   (gain_sn_cn),
        .o_gain_cn_mn   (gain_cn_mn),
        .o_gain_cn2_mn  (gain_cn2_mn),
        .o_m1_cn_drive  (m1_cn_drive),
        .o_m1_cn2_drive (m1_cn2_drive)
    );

    tick_timer u_timer (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_delay_max  (delay_max),
        .o_tick       (o_tick),
        .o_window_end (window_end)
    );

    ////////////////////
    // synapses
    ////////////////////

    // Ia and II share the sn-to-mn gain
    synapse_epsc u_syn_ia_mn (.ep50trig(ep50trig), .reset_sim(reset_sim), .i_tick(o_tick),
        .i_spk(i_sn_ia_spk), .i_gain(gain_sn_mn), .o_epsc(epsc_ia_mn));
    synapse_epsc u_syn_ii_mn (.ep50trig(ep50trig), .reset_sim(reset_sim), .i_tick(o_tick),
        .i_spk(i_sn_ii_spk), .i_gain(gain_sn_mn), .o_epsc(epsc_ii_mn));
    // one current feeds both cn and cn2
    synapse_epsc u_syn_sn_cn (.ep50trig(ep50trig), .reset_sim(reset_sim), .i_tick(o_tick),
        .i_spk(i_sn_ia_spk), .i_gain(gain_sn_cn), .o_epsc(epsc_sn_cn));
    synapse_epsc u_syn_cn_mn (.ep50trig(ep50trig), .reset_sim(reset_sim), .i_tick(o_tick),
        .i_spk(o_cn_spk), .i_gain(gain_cn_mn), .o_epsc(o_epsc_cn_to_mn));
    synapse_epsc u_syn_cn2_mn (.ep50trig(ep50trig), .reset_sim(reset_sim), .i_tick(o_tick),
        .i_spk(o_cn2_spk), .i_gain(gain_cn2_mn), .o_epsc(epsc_cn2_mn));

    ////////////////////
    // drives and neurons
    ////////////////////

    // sensory plus voluntary for the cortical pair
    assign cn_drive  = epsc_sn_cn + m1_cn_drive;
    assign cn2_drive = epsc_sn_cn + m1_cn2_drive;
    // short and long latency paths meet at mn
    assign mn_drive  = epsc_ia_mn + epsc_ii_mn + o_epsc_cn_to_mn + epsc_cn2_mn;

    if_neuron u_cn (.ep50trig(ep50trig), .reset_sim(reset_sim), .i_tick(o_tick),
        .i_drive(cn_drive), .o_spk(o_cn_spk));
    if_neuron u_cn2 (.ep50trig(ep50trig), .reset_sim(reset_sim), .i_tick(o_tick),
        .i_drive(cn2_drive), .o_spk(o_cn2_spk));
    if_neuron u_mn (.ep50trig(ep50trig), .reset_sim(reset_sim), .i_tick(o_tick),
        .i_drive(mn_drive), .o_spk(o_mn_spk));

    // mn spikes per population window
    spike_window_counter u_mn_count (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_tick       (o_tick),
        .i_window_end (window_end),
        .i_spk        (o_mn_spk),
        .o_count      (o_mn_spkcnt)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 10
)
(
    output logic o_clk,
    output logic o_rst
);

    // free running clock
    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    // reset from time zero, dropped just after an edge
    initial
    begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/reflex_loop_asserts.sv
`timescale 1ns/100ps
`include "reflex_params.svh"
`default_nettype none

module reflex_loop_asserts
(
    input wire logic                      ep50trig,
    input wire logic                      reset_sim,
    input wire logic [`REFLEX_WORD_W-1:0] i_delay_max,
    input wire logic                      i_tick,
    input wire logic                      i_cn_spk,
    input wire logic                      i_cn2_spk,
    input wire logic                      i_mn_spk,
    input wire neuro_pkg::current_t       i_epsc_cn_to_mn,
    input wire neuro_pkg::spkcnt_t        i_mn_spkcnt
);

    // assertion failures so far
    int fail_count = 0;

    ////////////////////
    // tick spacing
    ////////////////////

    // a tick restarts a full period, never back to back
    tick_spacing: assert property (@(posedge ep50trig) disable iff (reset_sim)
        (i_tick && (i_delay_max != 0)) |=> (!i_tick || (i_delay_max == 0)))
    else
    begin
        fail_count++;
        $error("tick high on two consecutive cycles");
    end

    // spike levels move only at a tick edge
    spike_timing: assert property (@(posedge ep50trig) disable iff (reset_sim)
        $changed({i_cn_spk, i_cn2_spk, i_mn_spk}) |-> $past(i_tick))
    else
    begin
        fail_count++;
        $error("spike level changed away from a tick");
    end

    ////////////////////
    // reset values
    ////////////////////

    reset_values: assert property (@(posedge ep50trig)
        reset_sim |-> (!i_tick && !i_cn_spk && !i_cn2_spk && !i_mn_spk
            && (i_epsc_cn_to_mn == 0) && (i_mn_spkcnt == 0)))
    else
    begin
        fail_count++;
        $error("output not zero during reset");
    end

endmodule

bind reflex_loop_top reflex_loop_asserts u_asserts (
    .ep50trig        (ep50trig),
    .reset_sim       (reset_sim),
    .i_delay_max     (delay_max),
    .i_tick          (o_tick),
    .i_cn_spk        (o_cn_spk),
    .i_cn2_spk       (o_cn2_spk),
    .i_mn_spk        (o_mn_spk),
    .i_epsc_cn_to_mn (o_epsc_cn_to_mn),
    .i_mn_spkcnt     (o_mn_spkcnt)
);

`default_nettype wire

// File: tests/reflex_loop_tb.sv
`timescale 1ns/100ps
`include "reflex_params.svh"
`default_nettype none

module reflex_loop_tb;

    import host_pkg::*;
    import neuro_pkg::*;

    localparam real CLK_NS      = 4.0;
    localparam int  MAX_DELAY   = 15;
    localparam int  RUN_WINDOWS = 3;
    // loop windows, one more for the short tests, then slack
    localparam real WATCHDOG_NS =
        (RUN_WINDOWS + 1) * `REFLEX_WINDOW_TICKS * (MAX_DELAY + 1) * CLK_NS + 4000.0;

    logic                      ep50trig;
    logic                      reset_sim;
    logic [`REFLEX_TRIG_W-1:0] i_trig;
    ep_half_t                  i_ep01, i_ep02, i_ep05, i_ep06, i_ep07, i_ep08;
    logic                      i_sn_ia_spk, i_sn_ii_spk;
    logic                      o_tick, o_cn_spk, o_cn2_spk, o_mn_spk;
    current_t                  o_epsc_cn_to_mn;
    spkcnt_t                   o_mn_spkcnt;

    // model state, bank then timer then loop
    logic [`REFLEX_WORD_W-1:0] m_delay, m_g_sn_mn, m_g_sn_cn, m_g_cn_mn, m_g_cn2_mn;
    current_t                  m_m1_cn, m_m1_cn2;
    logic [`REFLEX_WORD_W-1:0] m_period;
    int                        m_tick_cnt;
    current_t                  m_e_ia, m_e_ii, m_e_sn_cn, m_e_cn_mn, m_e_cn2_mn;
    longint                    m_v_cn, m_v_cn2, m_v_mn;
    logic                      m_s_cn, m_s_cn2, m_s_mn;
    spkcnt_t                   m_acc, m_count;

    // bookkeeping
    logic [31:0] rng_state;
    int          cycle_no, last_tick_cycle, tick_gap, n_ticks, n_win_ends;
    int          cn_spk_cycles, test_errors, n_pass, n_fail;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) u_clk (
        .o_clk (ep50trig),
        .o_rst (reset_sim)
    );

    reflex_loop_top uut (
        .ep50trig(ep50trig), .reset_sim(reset_sim), .i_trig(i_trig),
        .i_ep01(i_ep01), .i_ep02(i_ep02), .i_ep05(i_ep05), .i_ep06(i_ep06),
        .i_ep07(i_ep07), .i_ep08(i_ep08),
        .i_sn_ia_spk(i_sn_ia_spk), .i_sn_ii_spk(i_sn_ii_spk),
        .o_tick(o_tick), .o_cn_spk(o_cn_spk), .o_cn2_spk(o_cn2_spk), .o_mn_spk(o_mn_spk),
        .o_epsc_cn_to_mn(o_epsc_cn_to_mn), .o_mn_spkcnt(o_mn_spkcnt)
    );

    ////////////////////
    // model helpers
    ////////////////////

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // unit current times gain, low word kept
    function automatic current_t epsc_of(input logic [31:0] gain);
        logic [63:0] prod;
        prod = 64'(gain) * 64'(`REFLEX_EPSC_UNIT);
        return current_t'(prod[31:0]);
    endfunction

    // one tick of a non-leaky membrane
    task automatic integrate(input current_t drive, inout longint v, output logic spk);
        longint sum;
        sum = v + longint'(drive);
        if (sum >= `REFLEX_TH_SCALED)
        begin
            spk = 1'b1;
            v   = 0;
        end
        else
        begin
            spk = 1'b0;
            v   = (sum < 0) ? 0 : sum;
        end
    endtask

    task automatic reset_model();
        m_delay    = `REFLEX_DELAY_RST;
        m_g_sn_mn  = `REFLEX_GAIN_RST;
        m_g_sn_cn  = `REFLEX_GAIN_RST;
        m_g_cn_mn  = `REFLEX_GAIN_RST;
        m_g_cn2_mn = `REFLEX_GAIN_RST;
        {m_m1_cn, m_m1_cn2, m_period, m_tick_cnt} = '0;
        {m_e_ia, m_e_ii, m_e_sn_cn, m_e_cn_mn, m_e_cn2_mn} = '0;
        {m_v_cn, m_v_cn2, m_v_mn, m_s_cn, m_s_cn2, m_s_mn, m_acc, m_count} = '0;
    endtask

    // one clock edge of the model, inputs as driven this cycle
    task automatic advance_model();
        logic     tick;
        logic     win_end;
        current_t d_cn, d_cn2, d_mn;
        tick    = (m_period >= m_delay);
        win_end = tick && (m_tick_cnt == `REFLEX_WINDOW_TICKS - 1);
        // drives from the held epsc words, 32-bit wrap
        d_cn  = m_e_sn_cn + m_m1_cn;
        d_cn2 = m_e_sn_cn + m_m1_cn2;
        d_mn  = m_e_ia + m_e_ii + m_e_cn_mn + m_e_cn2_mn;
        if (tick)
        begin
            // synapses sample the old spike levels
            m_e_ia     = i_sn_ia_spk ? epsc_of(m_g_sn_mn) : '0;
            m_e_ii     = i_sn_ii_spk ? epsc_of(m_g_sn_mn) : '0;
            m_e_sn_cn  = i_sn_ia_spk ? epsc_of(m_g_sn_cn) : '0;
            m_e_cn_mn  = m_s_cn ? epsc_of(m_g_cn_mn) : '0;
            m_e_cn2_mn = m_s_cn2 ? epsc_of(m_g_cn2_mn) : '0;
            // window total includes this tick
            if (win_end)
            begin
                m_count = m_acc + spkcnt_t'(m_s_mn);
                m_acc   = '0;
            end
            else
                m_acc = m_acc + spkcnt_t'(m_s_mn);
            integrate(d_cn, m_v_cn, m_s_cn);
            integrate(d_cn2, m_v_cn2, m_s_cn2);
            integrate(d_mn, m_v_mn, m_s_mn);
            m_period   = '0;
            m_tick_cnt = (m_tick_cnt + 1) % `REFLEX_WINDOW_TICKS;
        end
        else
            m_period = m_period + 1;
        // new words count from the next cycle
        if (i_trig[TRIG_DELAY])
            m_delay = {i_ep02, i_ep01};
        if (i_trig[TRIG_GAIN_CN_MN])
            m_g_cn_mn = {i_ep02, i_ep01};
        if (i_trig[TRIG_GAIN_SN_MN])
            m_g_sn_mn = {i_ep02, i_ep01};
        if (i_trig[TRIG_GAIN_CN2_MN])
            m_g_cn2_mn = {i_ep02, i_ep01};
        if (i_trig[TRIG_GAIN_SN_CN])
            m_g_sn_cn = {i_ep02, i_ep01};
        if (i_trig[TRIG_M1_DRIVE])
        begin
            m_m1_cn  = {i_ep06, i_ep05};
            m_m1_cn2 = {i_ep08, i_ep07};
        end
    endtask

    ////////////////////
    // checks and stepping
    ////////////////////

    task automatic report_mismatch(input string what, input longint got, input longint exp);
        $display("[ERROR] t=%0t %s got %0d expected %0d", $time, what, got, exp);
        test_errors++;
    endtask

    task automatic check_outputs();
        logic tick;
        tick = (m_period >= m_delay);
        if (o_tick !== tick)
            report_mismatch("o_tick", o_tick, tick);
        if (o_cn_spk !== m_s_cn)
            report_mismatch("o_cn_spk", o_cn_spk, m_s_cn);
        if (o_cn2_spk !== m_s_cn2)
            report_mismatch("o_cn2_spk", o_cn2_spk, m_s_cn2);
        if (o_mn_spk !== m_s_mn)
            report_mismatch("o_mn_spk", o_mn_spk, m_s_mn);
        if (o_epsc_cn_to_mn !== m_e_cn_mn)
            report_mismatch("o_epsc_cn_to_mn", o_epsc_cn_to_mn, m_e_cn_mn);
        if (o_mn_spkcnt !== m_count)
            report_mismatch("o_mn_spkcnt", o_mn_spkcnt, m_count);
    endtask

    // called 1 ns after an edge, returns 1 ns after the next
    task automatic step_cycle();
        #2;
        check_outputs();
        if (o_tick)
        begin
            tick_gap        = cycle_no - last_tick_cycle;
            last_tick_cycle = cycle_no;
            n_ticks++;
        end
        if (o_cn_spk)
            cn_spk_cycles++;
        if ((m_period >= m_delay) && (m_tick_cnt == `REFLEX_WINDOW_TICKS - 1))
            n_win_ends++;
        advance_model();
        @(posedge ep50trig);
        #1;
        cycle_no++;
    endtask

    task automatic run_ticks(input int n);
        int stop;
        stop = n_ticks + n;
        while (n_ticks < stop)
            step_cycle();
    endtask

    task automatic load_word(input trig_idx_e idx, input logic [31:0] value);
        i_trig           = '0;
        i_trig[idx]      = 1'b1;
        {i_ep02, i_ep01} = value;
        step_cycle();
        i_trig = '0;
    endtask

    task automatic load_m1(input current_t cn, input current_t cn2);
        i_trig                 = '0;
        i_trig[TRIG_M1_DRIVE]  = 1'b1;
        {i_ep06, i_ep05}       = cn;
        {i_ep08, i_ep07}       = cn2;
        step_cycle();
        i_trig = '0;
    endtask

    task automatic check_gap(input int expected);
        if (tick_gap != expected)
        begin
            $display("[ERROR] t=%0t tick gap %0d expected %0d", $time, tick_gap, expected);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
        begin
            n_pass++;
            $display("PASS  %s", name);
        end
        else
        begin
            n_fail++;
            $display("FAIL  %s with %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial
    begin : main
        logic [31:0] r;
        int          delay;
        int          win_stop;
        logic        fire;
        rng_state = 32'd89;
        i_trig = '0;
        {i_ep01, i_ep02, i_ep05, i_ep06, i_ep07, i_ep08} = '0;
        i_sn_ia_spk = 1'b0;
        i_sn_ii_spk = 1'b0;
        {cycle_no, last_tick_cycle, tick_gap, n_ticks, n_win_ends} = '0;
        {cn_spk_cycles, test_errors, n_pass, n_fail} = '0;
        reset_model();
        @(negedge reset_sim);

        // reset defaults, first tick after the reset period
        run_ticks(1);
        if (last_tick_cycle != `REFLEX_DELAY_RST)
        begin
            $display("[ERROR] t=%0t first tick at cycle %0d expected %0d",
                $time, last_tick_cycle, `REFLEX_DELAY_RST);
            test_errors++;
        end
        for (int k = 0; k < 3; k++)
        begin
            run_ticks(1);
            check_gap(`REFLEX_DELAY_RST + 1);
        end
        finish_test("reset defaults");

        // new divider period, one period to settle
        r     = next_random();
        delay = 2 + int'(r % 14);
        load_word(TRIG_DELAY, delay);
        run_ticks(1);
        for (int k = 0; k < 4; k++)
        begin
            run_ticks(1);
            check_gap(delay + 1);
        end
        finish_test("parameter load");

        // cn fired on chosen ticks, full width gains
        load_word(TRIG_GAIN_CN_MN, next_random());
        load_word(TRIG_GAIN_CN2_MN, next_random());
        for (int k = 0; k < 8; k++)
        begin
            r    = next_random();
            fire = (k == 0) || r[0];
            load_m1(fire ? current_t'(`REFLEX_TH_SCALED) : current_t'(0), '0);
            run_ticks(1);
        end
        run_ticks(2);
        finish_test("synapse current");

        // voluntary drive alone, sensory side quiet
        r = next_random();
        load_m1(current_t'(1 + (r % (2 * `REFLEX_TH_SCALED))),
            current_t'(1 + (next_random() % (2 * `REFLEX_TH_SCALED))));
        run_ticks(24);
        load_m1(current_t'(-(1 + int'(next_random() % 65536))),
            current_t'(-(1 + int'(next_random() % 65536))));
        run_ticks(1);
        cn_spk_cycles = 0;
        run_ticks(10);
        if (cn_spk_cycles != 0)
        begin
            $display("[ERROR] t=%0t cn spiked on %0d cycles under negative drive",
                $time, cn_spk_cycles);
            test_errors++;
        end
        finish_test("m1 voluntary drive");

        // whole loop, random sensory levels per tick
        load_word(TRIG_DELAY, 2 + (next_random() % 14));
        load_word(TRIG_GAIN_SN_MN, 1 + (next_random() % 16));
        load_word(TRIG_GAIN_SN_CN, 1 + (next_random() % 16));
        load_word(TRIG_GAIN_CN_MN, 1 + (next_random() % 16));
        load_word(TRIG_GAIN_CN2_MN, 1 + (next_random() % 16));
        load_m1(current_t'(int'(next_random() % `REFLEX_TH_SCALED) - `REFLEX_TH_SCALED / 4),
            current_t'(int'(next_random() % `REFLEX_TH_SCALED) - `REFLEX_TH_SCALED / 4));
        win_stop = n_win_ends + RUN_WINDOWS;
        while (n_win_ends < win_stop)
        begin
            // new levels at the start of each tick period
            if (m_period == 0)
            begin
                r           = next_random();
                i_sn_ia_spk = r[0];
                i_sn_ii_spk = r[1];
            end
            step_cycle();
        end
        i_sn_ia_spk = 1'b0;
        i_sn_ii_spk = 1'b0;
        run_ticks(1);
        finish_test("full reflex loop");

        $display("tests passed %0d, failed %0d, assertion failures %0d",
            n_pass, n_fail, uut.u_asserts.fail_count);
        if ((n_fail == 0) && (uut.u_asserts.fail_count == 0))
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // hard stop if ticks never come
    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/host_pkg.sv
logic/neuro_pkg.sv
logic/param_bank.sv
logic/tick_timer.sv
logic/synapse_epsc.sv
logic/if_neuron.sv
logic/spike_window_counter.sv
logic/reflex_loop_top.sv
tests/tb_clock_gen.sv
tests/reflex_loop_asserts.sv
tests/reflex_loop_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module reflex_loop_tb -o reflex_sim

# the log decides pass or fail, not the exit status
./obj_dir/reflex_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1
